//--- source/mExtPkg.sv
/*
 RISC-V M extension operation codes, encoded exactly as funct3
 Only the eight OP / OP-32 codes with funct7 = 0000001 are listed
 Decoding of funct7 and opcode happens outside this unit
*/
`default_nettype none

package mExtPkg;

   ////////////////////
   // Field widths
   ////////////////////

   // Width of the funct3 field carried down the pipeline
   localparam int funct3Width = 3;

   ////////////////////
   // Operation codes
   ////////////////////

   // RISC-V order; bit 2 marks divide/remainder, bit 0 marks unsigned divide
   typedef enum logic [funct3Width-1:0] {
      opMul    = 3'd0,
      opMulh   = 3'd1,
      opMulhsu = 3'd2,
      opMulhu  = 3'd3,
      opDiv    = 3'd4,
      opDivu   = 3'd5,
      opRem    = 3'd6,
      opRemu   = 3'd7
   } mulDivOp;

endpackage

`default_nettype wire

//--- source/divPkg.sv
/*
 Divider sequencing states
 divDone lasts one cycle and marks valid quotient and remainder
*/
`default_nettype none

package divPkg;

   ////////////////////
   // Divider FSM
   ////////////////////

   // divIdle waits for a start
   // divRun shifts one quotient bit per cycle, XLEN cycles
   // divDone raises the done pulse for one cycle
   typedef enum logic [1:0] {
      divIdle = 2'd0,
      divRun  = 2'd1,
      divDone = 2'd2
   } divState;

endpackage

`default_nettype wire

//--- source/mulUnit.sv
/*
 Single-cycle XLEN x XLEN multiplier for MUL, MULH, MULHSU, MULHU
 Purely combinational, so the caller owns the pipeline register
 The low product half is identical for every code
*/
`timescale 1ns/100ps
`default_nettype none

module mulUnit #(
   parameter int XLEN = 64
) (
   input  logic [XLEN-1:0]   xE,
   input  logic [XLEN-1:0]   yE,
   input  mExtPkg::mulDivOp  funct3E,
   output logic [2*XLEN-1:0] prodE
);

   import mExtPkg::*;

   // Per-operand signedness picked by the operation
   logic signedX;
   logic signedY;

   // Operands widened by one bit so a single signed multiply covers all cases
   logic signed [XLEN:0]     xExt;
   logic signed [XLEN:0]     yExt;
   logic signed [2*XLEN+1:0] fullProd;

   ////////////////////
   // Sign selection
   ////////////////////
   always_comb begin
      signedX = 1'b0;
      signedY = 1'b0;
      case (funct3E)
         opMulh: begin
            signedX = 1'b1;
            signedY = 1'b1;
         end
         // rs1 signed, rs2 unsigned
         opMulhsu: signedX = 1'b1;
         default: begin
            signedX = 1'b0;
            signedY = 1'b0;
         end
      endcase
   end

   // Extra top bit is the sign bit or zero
   assign xExt = {signedX & xE[XLEN-1], xE};
   assign yExt = {signedY & yE[XLEN-1], yE};

   ////////////////////
   // Product
   ////////////////////
   assign fullProd = xExt * yExt;

   // Top two bits are only sign copies
   assign prodE = fullProd[2*XLEN-1:0];

endmodule

`default_nettype wire

//--- source/intDivRestoring.sv
/*
 Iterative restoring divider, one quotient bit per cycle
 Start is accepted only in divIdle
 XLEN cycles after the start the done output pulses once
 quotM and remM stay valid from divDone until the next start
 Divide by zero and overflow give the RISC-V results without a trap
 flushM aborts a running divide without a done pulse
*/
`timescale 1ns/100ps
`default_nettype none

module intDivRestoring #(
   parameter int XLEN = 64
) (
   input  logic            clk,
   input  logic            rstN,
   input  logic            flushM,
   input  logic            startDivideE,
   input  logic            signedDivideE,
   input  logic [XLEN-1:0] xE,
   input  logic [XLEN-1:0] dE,
   output logic            busyE,
   output logic            done,
   output logic [XLEN-1:0] quotM,
   output logic [XLEN-1:0] remM
);

   import divPkg::*;

   localparam int cntWidth = $clog2(XLEN);

   divState state;

   // Iteration count with the last step at XLEN-1
   logic [cntWidth-1:0] iter;

   // Dividend bits leave the top of quotReg as quotient bits enter at the bottom
   logic [XLEN-1:0] quotReg;
   logic [XLEN-1:0] remReg;
   logic [XLEN-1:0] dReg;
   logic            negQ;
   logic            negR;

   // Magnitudes of the incoming operands
   logic [XLEN-1:0] xAbs;
   logic [XLEN-1:0] dAbs;
   logic            xNeg;
   logic            dNeg;

   // One restoring step
   logic [XLEN:0]   shifted;
   logic [XLEN+1:0] diff;
   logic            stepNeg;

   ////////////////////
   // Operand prep
   ////////////////////
   assign xNeg = signedDivideE & xE[XLEN-1];
   assign dNeg = signedDivideE & dE[XLEN-1];

   // The most negative value maps to itself and reads correctly as unsigned
   assign xAbs = xNeg ? -xE : xE;
   assign dAbs = dNeg ? -dE : dE;

   ////////////////////
   // Restoring step
   ////////////////////
   // Partial remainder stays below the divisor, so one extra bit holds the shift
   assign shifted = {remReg, quotReg[XLEN-1]};
   assign diff    = {1'b0, shifted} - {2'b00, dReg};
   assign stepNeg = diff[XLEN+1];

   ////////////////////
   // Control FSM
   ////////////////////
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state <= divIdle;
         iter  <= '0;
      end else if (flushM) begin
         // Abort without a done pulse
         state <= divIdle;
         iter  <= '0;
      end else begin
         case (state)
            divIdle: begin
               if (startDivideE) begin
                  state <= divRun;
                  iter  <= '0;
               end
            end
            divRun: begin
               iter <= iter + 1'b1;
               if (iter == cntWidth'(XLEN - 1)) state <= divDone;
            end
            divDone: state <= divIdle;
            default: state <= divIdle;
         endcase
      end
   end

   ////////////////////
   // Datapath
   ////////////////////
   always_ff @(posedge clk) begin
      if (state == divIdle && startDivideE && !flushM) begin
         quotReg <= xAbs;
         dReg    <= dAbs;
         remReg  <= '0;
         // Quotient sign flips only for a nonzero divisor
         negQ    <= (xNeg ^ dNeg) & (dE != '0);
         // Remainder follows the dividend
         negR    <= xNeg;
      end else if (state == divRun) begin
         // Keep the difference when it is not negative
         remReg  <= stepNeg ? shifted[XLEN-1:0] : diff[XLEN-1:0];
         quotReg <= {quotReg[XLEN-2:0], ~stepNeg};
      end
   end

   ////////////////////
   // Outputs
   ////////////////////
   assign busyE = (state == divRun);
   assign done  = (state == divDone);

   // Sign fix-up holds until the next start reloads the registers
   assign quotM = negQ ? -quotReg : quotReg;
   assign remM  = negR ? -remReg : remReg;

   ////////////////////
   // Checks
   ////////////////////
   // The top must block a new start while iterating
   assert property (@(posedge clk) disable iff (!rstN)
      (state == divRun) |-> !startDivideE)
      else $error("divider started while in divRun");

   // Done comes XLEN + 1 cycles after an accepted start, so it pulses once
   assert property (@(posedge clk) disable iff (!rstN)
      done |-> $past(state == divIdle && startDivideE && !flushM, XLEN + 1))
      else $error("divider done not XLEN + 1 cycles after an accepted start");

endmodule

`default_nettype wire

//--- source/mulDiv.sv
/*
 RISC-V M extension unit, Execute to Writeback
 XLEN is 32 or 64; w64E only matters at 64 and selects the W-type forms
 Multiplies take two edges to mulDivResultW, divides XLEN + 3 edges
 The core must hold Execute and Memory while divBusyE is high
*/
`timescale 1ns/100ps
`default_nettype none

module mulDiv #(
   parameter int XLEN = 64
) (
   input  logic             clk,
   input  logic             rstN,
   // Execute stage
   input  logic [XLEN-1:0]  srcAE,
   input  logic [XLEN-1:0]  srcBE,
   input  mExtPkg::mulDivOp funct3E,
   input  mExtPkg::mulDivOp funct3M,
   input  logic             mulDivE,
   input  logic             w64E,
   // Pipeline control
   input  logic             stallE,
   input  logic             stallM,
   input  logic             stallW,
   input  logic             flushM,
   input  logic             flushW,
   // Results and status
   output logic [XLEN-1:0]  mulDivResultW,
   output logic             divDoneE,
   output logic             divBusyE
);

   import mExtPkg::*;

   logic [XLEN-1:0]   xE;
   logic [XLEN-1:0]   dE;
   logic [2*XLEN-1:0] prodE;
   logic [2*XLEN-1:0] prodM;
   logic              w64M;
   logic [XLEN-1:0]   quotM;
   logic [XLEN-1:0]   remM;
   logic [XLEN-1:0]   prelimResultM;
   logic [XLEN-1:0]   mulDivResultM;
   logic              startDivideE;
   logic              signedDivideE;
   logic              busyE;

   ////////////////////
   // Multiplier
   ////////////////////
   // Raw operands; the W form only keeps the low half anyway
   mulUnit #(.XLEN(XLEN)) i_mul (
      .xE      (srcAE),
      .yE      (srcBE),
      .funct3E (funct3E),
      .prodE   (prodE)
   );

   ////////////////////
   // Divider operands
   ////////////////////
   // DIV and REM are signed, DIVU and REMU are not
   assign signedDivideE = ~funct3E[0];

   // W-type: upper bits follow bit 31, or zero for unsigned
   // No loop iterations at XLEN 32
   always_comb begin
      xE = srcAE;
      dE = srcBE;
      if (w64E) begin
         for (int i = 32; i < XLEN; i++) begin
            xE[i] = srcAE[31] & signedDivideE;
            dE[i] = srcBE[31] & signedDivideE;
         end
      end
   end

   // New divide only from idle, never on the done cycle
   assign startDivideE = mulDivE & funct3E[2] & ~busyE & ~divDoneE;
   assign divBusyE     = startDivideE | busyE;

   intDivRestoring #(.XLEN(XLEN)) i_div (
      .clk           (clk),
      .rstN          (rstN),
      .flushM        (flushM),
      .startDivideE  (startDivideE),
      .signedDivideE (signedDivideE),
      .xE            (xE),
      .dE            (dE),
      .busyE         (busyE),
      .done          (divDoneE),
      .quotM         (quotM),
      .remM          (remM)
   );

   ////////////////////
   // Memory stage
   ////////////////////
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         prodM <= '0;
         w64M  <= 1'b0;
      end else if (!stallM) begin
         if (flushM) begin
            prodM <= '0;
            w64M  <= 1'b0;
         end else begin
            prodM <= prodE;
            w64M  <= w64E;
         end
      end
   end

   always_comb begin
      case (funct3M)
         opMul:                      prelimResultM = prodM[XLEN-1:0];
         opMulh, opMulhsu, opMulhu:  prelimResultM = prodM[2*XLEN-1:XLEN];
         opDiv, opDivu:              prelimResultM = quotM;
         opRem, opRemu:              prelimResultM = remM;
         default:                    prelimResultM = '0;
      endcase
   end

   // W-type results are 32-bit values sign-extended to XLEN
   always_comb begin
      mulDivResultM = prelimResultM;
      if (w64M) begin
         for (int i = 32; i < XLEN; i++) mulDivResultM[i] = prelimResultM[31];
      end
   end

   ////////////////////
   // Writeback stage
   ////////////////////
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         mulDivResultW <= '0;
      end else if (!stallW) begin
         mulDivResultW <= flushW ? '0 : mulDivResultM;
      end
   end

   ////////////////////
   // Checks
   ////////////////////
   // While the divider is in divRun, a divide sitting in Execute must be stalled
   assert property (@(posedge clk) disable iff (!rstN)
      (busyE && mulDivE && funct3E[2]) |-> stallE)
      else $error("divide presented without stallE while divider in divRun");

endmodule

`default_nettype wire

//--- tb/mulDivRef.svh
/*
 Expected results for the M extension unit, plus the stimulus LFSR
 Included inside the testbench module after XLEN and the mExtPkg import
 W-type results assume XLEN = 64
*/
`ifndef mulDivRefSvh
`define mulDivRefSvh

////////////////////
// Operand widening
////////////////////

// Value of the low width bits, read as signed or unsigned, in two spare bits
function automatic logic signed [XLEN+1:0] widenOperand(input logic [XLEN-1:0] v,
                                                        input int width,
                                                        input logic isSigned);
   logic signed [XLEN+1:0] w;
   w = '0;
   for (int i = 0; i < XLEN + 2; i++) begin
      if (i < width) w[i] = v[i];
      else w[i] = isSigned & v[width-1];
   end
   return w;
endfunction

////////////////////
// Reference model
////////////////////

function automatic logic [XLEN-1:0] refMulDiv(input mulDivOp op, input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b, input logic w64);
   logic signed [XLEN+1:0]   wa;
   logic signed [XLEN+1:0]   wb;
   logic signed [XLEN+1:0]   minNegW;
   logic signed [XLEN+1:0]   res;
   logic signed [2*XLEN+3:0] prod;
   logic [XLEN-1:0]          out;
   int                       width;
   logic                     isSigned;
   if (!op[2]) begin
      // MULW keeps only the low half, so the full-width product serves both
      wa   = widenOperand(a, XLEN, op == opMulh || op == opMulhsu);
      wb   = widenOperand(b, XLEN, op == opMulh);
      prod = wa * wb;
      out  = (op == opMul) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
   end else begin
      width    = w64 ? 32 : XLEN;
      isSigned = (op == opDiv || op == opRem);
      wa       = widenOperand(a, width, isSigned);
      wb       = widenOperand(b, width, isSigned);
      minNegW  = widenOperand(XLEN'(1) << (width - 1), width, 1'b1);
      if (wb == 0) begin
         // Divide by zero: all-ones quotient, remainder is the dividend
         res = (op == opRem || op == opRemu) ? wa : '1;
      end else if (isSigned && wa == minNegW && wb == -1) begin
         // Signed overflow: quotient is the dividend, remainder zero
         res = (op == opRem) ? '0 : wa;
      end else begin
         // Truncating division, remainder takes the dividend sign
         res = (op == opRem || op == opRemu) ? wa % wb : wa / wb;
      end
      out = res[XLEN-1:0];
   end
   // W forms return a sign-extended 32-bit value
   if (w64) out = {{(XLEN-32){out[31]}}, out[31:0]};
   return out;
endfunction

////////////////////
// Stimulus LFSR
////////////////////

// Fibonacci form, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

//--- tb/mulDivTb.sv
/*
 Testbench for mulDiv at XLEN = 64, playing the core pipeline
 Stalls and flushes are driven as plain levels, 1 ns after each rising edge
 Outputs are sampled 1 ns after the edge, before new inputs are driven
*/
`timescale 1ns/100ps
`default_nettype none

module mulDivTb;

   import mExtPkg::*;

   localparam int XLEN       = 64;
   localparam int randPerOp  = 6;
   localparam int wPerOp     = 4;
   // Edge, random mul and div, corners, W-type, pipeline control
   localparam int numOps     = 64 + 8 * randPerOp + 14 + 5 * wPerOp + 4;
   localparam int cycleLimit = numOps * (XLEN + 6) + 200;

   localparam logic [XLEN-1:0] minNeg = {1'b1, {(XLEN-1){1'b0}}};

   logic            clk;
   logic            rstN;
   logic [XLEN-1:0] srcAE;
   logic [XLEN-1:0] srcBE;
   mulDivOp         funct3E;
   mulDivOp         funct3M;
   logic            mulDivE;
   logic            w64E;
   logic            stallE;
   logic            stallM;
   logic            stallW;
   logic            flushM;
   logic            flushW;
   logic [XLEN-1:0] mulDivResultW;
   logic            divDoneE;
   logic            divBusyE;

   int              errors = 0;
   int              cycles = 0;
   logic [31:0]     lfsr   = 32'd53;

   `include "mulDivRef.svh"

   mulDiv #(.XLEN(XLEN)) i_dut (
      .clk           (clk),
      .rstN          (rstN),
      .srcAE         (srcAE),
      .srcBE         (srcBE),
      .funct3E       (funct3E),
      .funct3M       (funct3M),
      .mulDivE       (mulDivE),
      .w64E          (w64E),
      .stallE        (stallE),
      .stallM        (stallM),
      .stallW        (stallW),
      .flushM        (flushM),
      .flushW        (flushW),
      .mulDivResultW (mulDivResultW),
      .divDoneE      (divDoneE),
      .divBusyE      (divBusyE)
   );

   // 40 ns period
   always #20 clk = ~clk;

   // Hang guard
   always @(posedge clk) begin
      cycles++;
      if (cycles > cycleLimit) begin
         $display("Timeout: the run hung after %0d cycles", cycles);
         $display("TB FAILED");
         $finish;
      end
   end

   ////////////////////
   // Helpers
   ////////////////////

   task automatic checkValue(input string name, input logic [XLEN-1:0] expected,
                             input logic [XLEN-1:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("ERR %s expected %h actual %h", name, expected, actual);
      end
   endtask

   // One LFSR step per bit
   task automatic randomBits(input int count, output logic [XLEN-1:0] w);
      w = '0;
      for (int i = 0; i < count; i++) begin
         lfsr = lfsrNext(lfsr);
         w[i] = lfsr[0];
      end
   endtask

   // Divisor of random magnitude and sign, so quotients vary
   task automatic randomDivisor(output logic [XLEN-1:0] b);
      logic [XLEN-1:0] s;
      logic [XLEN-1:0] n;
      randomBits(XLEN, b);
      randomBits(6, s);
      randomBits(1, n);
      b = b >> s[5:0];
      if (n[0]) b = -b;
   endtask

   // One operation through Execute, Memory and Writeback
   task automatic runOp(input string name, input mulDivOp op, input logic [XLEN-1:0] a,
                        input logic [XLEN-1:0] b, input logic w64);
      logic [XLEN-1:0] expected;
      int              edges;
      int              busyGaps;
      expected = refMulDiv(op, a, b, w64);
      edges    = 0;
      busyGaps = 0;
      srcAE    = a;
      srcBE    = b;
      funct3E  = op;
      w64E     = w64;
      mulDivE  = 1'b1;
      if (op[2]) begin
         // Core holds Execute and Memory for the whole divide
         stallE = 1'b1;
         stallM = 1'b1;
         do begin
            @(posedge clk);
            #1;
            edges++;
            if (!divDoneE && !divBusyE) busyGaps++;
         end while (!divDoneE);
         checkValue({name, " done edge"}, XLEN'(XLEN + 1), XLEN'(edges));
         checkValue({name, " busy gap"}, '0, XLEN'(busyGaps));
         // Pipeline advances on the done cycle
         stallE = 1'b0;
         stallM = 1'b0;
      end
      @(posedge clk);
      #1;
      if (op[2]) checkValue({name, " done pulse"}, '0, XLEN'(divDoneE));
      mulDivE = 1'b0;
      funct3M = op;
      @(posedge clk);
      #1;
      checkValue(name, expected, mulDivResultW);
   endtask

   ////////////////////
   // Test sequence
   ////////////////////
   initial begin
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
      logic [XLEN-1:0] held;
      logic [XLEN-1:0] edgeVals [4];
      mulDivOp         wOps [5];
      mulDivOp         opSel;
      int              donePulses;
      clk     = 1'b0;
      rstN    = 1'b0;
      srcAE   = '0;
      srcBE   = '0;
      funct3E = opMul;
      funct3M = opMul;
      mulDivE = 1'b0;
      w64E    = 1'b0;
      stallE  = 1'b0;
      stallM  = 1'b0;
      stallW  = 1'b0;
      flushM  = 1'b0;
      flushW  = 1'b0;
      edgeVals = '{'0, XLEN'(1), '1, minNeg};
      wOps     = '{opMul, opDiv, opDivu, opRem, opRemu};

      repeat (4) @(posedge clk);
      #1;
      rstN = 1'b1;
      checkValue("reset busy", '0, XLEN'(divBusyE));
      checkValue("reset done", '0, XLEN'(divDoneE));
      checkValue("reset result", '0, mulDivResultW);

      // Multiply codes on every pair of edge operands
      for (int i = 0; i < 4; i++) begin
         for (int j = 0; j < 4; j++) begin
            for (int k = 0; k < 4; k++) begin
               opSel = mulDivOp'(k);
               runOp($sformatf("%s edge", opSel.name()), opSel, edgeVals[i], edgeVals[j], 1'b0);
            end
         end
      end

      // Random multiplies, then random divides and remainders
      for (int k = 0; k < 4; k++) begin
         opSel = mulDivOp'(k);
         for (int n = 0; n < randPerOp; n++) begin
            randomBits(XLEN, a);
            randomBits(XLEN, b);
            runOp($sformatf("%s random", opSel.name()), opSel, a, b, 1'b0);
         end
      end
      for (int k = 4; k < 8; k++) begin
         opSel = mulDivOp'(k);
         for (int n = 0; n < randPerOp; n++) begin
            randomBits(XLEN, a);
            randomDivisor(b);
            runOp($sformatf("%s random", opSel.name()), opSel, a, b, 1'b0);
         end
      end

      ////////////////////
      // Corner cases
      ////////////////////
      for (int k = 4; k < 8; k++) begin
         opSel = mulDivOp'(k);
         randomBits(XLEN, a);
         runOp($sformatf("%s by zero", opSel.name()), opSel, a, '0, 1'b0);
         runOp($sformatf("%s min by zero", opSel.name()), opSel, minNeg, '0, 1'b0);
      end
      runOp("DIV overflow", opDiv, minNeg, '1, 1'b0);
      runOp("REM overflow", opRem, minNeg, '1, 1'b0);
      // Upper halves are junk that W forms must ignore
      runOp("DIVW by zero", opDiv, 64'hDEADBEEF_87654321, 64'hFFFF0000_00000000, 1'b1);
      runOp("REMW by zero", opRem, 64'hDEADBEEF_87654321, 64'hFFFF0000_00000000, 1'b1);
      runOp("DIVW overflow", opDiv, 64'h00000001_80000000, 64'h00000000_FFFFFFFF, 1'b1);
      runOp("REMW overflow", opRem, 64'h00000001_80000000, 64'h00000000_FFFFFFFF, 1'b1);

      // W-type forms
      for (int k = 0; k < 5; k++) begin
         for (int n = 0; n < wPerOp; n++) begin
            randomBits(XLEN, a);
            randomDivisor(b);
            runOp($sformatf("%s W", wOps[k].name()), wOps[k], a, b, 1'b1);
         end
      end

      ////////////////////
      // Pipeline control
      ////////////////////
      randomBits(XLEN, a);
      randomBits(XLEN, b);
      held = refMulDiv(opMul, a, b, 1'b0);
      runOp("stallW first", opMul, a, b, 1'b0);
      randomBits(XLEN, a);
      randomBits(XLEN, b);
      srcAE   = a;
      srcBE   = b;
      funct3E = opMulhu;
      w64E    = 1'b0;
      mulDivE = 1'b1;
      @(posedge clk);
      #1;
      mulDivE = 1'b0;
      funct3M = opMulhu;
      stallW  = 1'b1;
      repeat (2) begin
         @(posedge clk);
         #1;
         checkValue("stallW hold", held, mulDivResultW);
      end
      stallW = 1'b0;
      @(posedge clk);
      #1;
      checkValue("stallW release", refMulDiv(opMulhu, a, b, 1'b0), mulDivResultW);
      flushW = 1'b1;
      @(posedge clk);
      #1;
      checkValue("flushW clear", '0, mulDivResultW);
      flushW = 1'b0;

      // Divide aborted by flushM partway through
      randomBits(XLEN, a);
      randomDivisor(b);
      srcAE   = a;
      srcBE   = b;
      funct3E = opDiv;
      mulDivE = 1'b1;
      stallE  = 1'b1;
      stallM  = 1'b1;
      repeat (5) begin
         @(posedge clk);
         #1;
      end
      checkValue("flushM busy before", XLEN'(1), XLEN'(divBusyE));
      flushM  = 1'b1;
      mulDivE = 1'b0;
      stallE  = 1'b0;
      stallM  = 1'b0;
      @(posedge clk);
      #1;
      checkValue("flushM busy after", '0, XLEN'(divBusyE));
      flushM     = 1'b0;
      donePulses = 0;
      repeat (XLEN + 4) begin
         @(posedge clk);
         #1;
         if (divDoneE) donePulses++;
      end
      checkValue("flushM done pulse", '0, XLEN'(donePulses));
      runOp("DIV after flush", opDiv, a, b, 1'b0);

      $display("Checks finished with %0d errors", errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- mulDiv.f
+incdir+tb
source/mExtPkg.sv
source/divPkg.sv
source/mulUnit.sv
source/intDivRestoring.sv
source/mulDiv.sv
tb/mulDivTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the mulDiv testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f mulDiv.f --top-module mulDivTb -o simMulDiv

# A stopped simulation still reaches the search below
output=$(./obj_dir/simMulDiv 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "TB PASSED"; then
   exit 0
fi
echo "Simulation did not report a pass"
exit 1
